/* verilog/pcie_dll_pkg.sv */
/*
 * pcie_dll_pkg
 * shared DLLP types, stream beat and request structs, advertised
 * init credits and the CRC-16 constants of the data link layer
 */
`default_nettype none

package pcie_dll_pkg;

  // DLLP type byte
  typedef enum logic [7:0] {
    DLLP_ACK     = 8'h00,
    DLLP_NAK     = 8'h10,
    INITFC1_P    = 8'h40,
    INITFC1_NP   = 8'h50,
    INITFC1_CPL  = 8'h60,
    INITFC2_P    = 8'hC0,
    INITFC2_NP   = 8'hD0,
    INITFC2_CPL  = 8'hE0,
    UPDATEFC_P   = 8'h80,
    UPDATEFC_NP  = 8'h90,
    UPDATEFC_CPL = 8'hA0
  } dllp_type_e;

  // 32-bit body, Ack/Nak put the sequence number in data_fc
  typedef struct packed {
    dllp_type_e  dllp_type;
    logic [1:0]  rsvd_hi;
    logic [7:0]  hdr_fc;
    logic [1:0]  rsvd_lo;
    logic [11:0] data_fc;
  } dllp_t;

  typedef struct packed {
    logic [31:0] data;
    logic        is_dllp;
    logic        last;
  } phy_beat_t;

  typedef struct packed {
    logic        vld;
    logic        is_ack;
    logic [11:0] seq;
  } seq_ack_t;

  typedef struct packed {
    logic [7:0]  ph;
    logic [11:0] pd;
    logic [7:0]  nph;
    logic [11:0] npd;
  } fc_credits_t;

  typedef struct packed {
    logic        vld;
    logic        good;
    logic [11:0] seq;
  } rx_tlp_t;

  typedef struct packed {
    logic       p_hdr;
    logic [3:0] p_data;
    logic       np_hdr;
    logic [3:0] np_data;
  } fc_release_t;

  typedef struct packed {
    logic  vld;
    dllp_t body;
  } dllp_req_t;

  // receive credits advertised first
  localparam logic [7:0]  INIT_PH  = 8'd32;
  localparam logic [11:0] INIT_PD  = 12'd256;
  localparam logic [7:0]  INIT_NPH = 8'd16;
  localparam logic [11:0] INIT_NPD = 12'd64;

  // six InitFC DLLPs before updates may go out
  localparam logic [2:0]  FC_INIT_STEPS = 3'd6;

  localparam logic [15:0] CRC_POLY = 16'h100B;
  localparam logic [15:0] CRC_INIT = 16'hFFFF;

endpackage

`default_nettype wire

/* verilog/dllp_crc16.sv */
/*
 * dllp_crc16
 * combinational CRC-16 over a 32-bit DLLP body, msb first,
 * result inverted as it goes on the wire
 */
`default_nettype none

module dllp_crc16 (
  input  pcie_dll_pkg::dllp_t body_i,
  output logic [15:0]         crc_o
);
  import pcie_dll_pkg::*;

  logic [31:0] body_bits;
  logic [15:0] lfsr_c;

  assign body_bits = body_i;

  // one shift per body bit, fully unrolled
  always_comb begin
    lfsr_c = CRC_INIT;
    for (int i = 31; i >= 0; i--) begin
      if (lfsr_c[15] ^ body_bits[i]) begin
        lfsr_c = {lfsr_c[14:0], 1'b0} ^ CRC_POLY;
      end else begin
        lfsr_c = {lfsr_c[14:0], 1'b0};
      end
    end
  end

  assign crc_o = ~lfsr_c;

endmodule

`default_nettype wire

/* verilog/dllp_handler.sv */
/*
 * dllp_handler
 * receives two-beat DLLPs from the physical layer, checks the CRC
 * and decodes Ack/Nak and flow-control packets
 */
`default_nettype none

module dllp_handler (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      link_up_i,
  input  logic                      rx_valid_i,
  input  pcie_dll_pkg::phy_beat_t   rx_beat_i,
  output logic                      rx_ready_o,
  output pcie_dll_pkg::seq_ack_t    ack_o,
  output pcie_dll_pkg::fc_credits_t tx_fc_o,
  output logic                      fc1_done_o,
  output logic                      fc2_done_o,
  output logic                      crc_err_o
);
  import pcie_dll_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK_CRC,
    ST_PROCESS
  } rx_state_e;

  rx_state_e   state_r;
  dllp_t       body_r;
  logic [15:0] body_crc;
  logic        rx_xfer;
  logic        crc_ok;
  logic        take_body;
  logic        in_process;
  logic        is_p;
  logic        is_np;
  logic        crc_err_r;
  fc_credits_t tx_fc_r;
  // bit 0 P, bit 1 NP, bit 2 Cpl
  logic [2:0]  fc1_seen_r;
  logic [2:0]  fc2_seen_r;

  dllp_crc16 crc_i (
    .body_i(body_r),
    .crc_o (body_crc)
  );

  always_comb begin
    case (state_r)
      ST_IDLE:      rx_ready_o = link_up_i;
      ST_CHECK_CRC: rx_ready_o = 1'b1;
      default:      rx_ready_o = 1'b0;
    endcase
  end

  assign rx_xfer    = rx_valid_i && rx_ready_o;
  assign crc_ok     = rx_beat_i.data[15:0] == body_crc;
  // non-DLLP beats in idle are accepted and dropped
  assign take_body  = (state_r == ST_IDLE) && rx_xfer && rx_beat_i.is_dllp;
  assign in_process = state_r == ST_PROCESS;

  assign is_p  = body_r.dllp_type inside {INITFC1_P, INITFC2_P, UPDATEFC_P};
  assign is_np = body_r.dllp_type inside {INITFC1_NP, INITFC2_NP, UPDATEFC_NP};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r   <= ST_IDLE;
      crc_err_r <= 1'b0;
    end else begin
      crc_err_r <= 1'b0;
      case (state_r)
        ST_IDLE: begin
          if (take_body) begin
            state_r <= ST_CHECK_CRC;
          end
        end
        ST_CHECK_CRC: begin
          if (rx_xfer && crc_ok) begin
            state_r <= ST_PROCESS;
          end else if (rx_xfer) begin
            state_r   <= ST_IDLE;
            crc_err_r <= 1'b1;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_body) begin
      body_r <= dllp_t'(rx_beat_i.data);
    end
  end

  // credit limits and init flags update as process ends
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_fc_r    <= '0;
      fc1_seen_r <= '0;
      fc2_seen_r <= '0;
    end else if (in_process) begin
      if (is_p) begin
        tx_fc_r.ph <= body_r.hdr_fc;
        tx_fc_r.pd <= body_r.data_fc;
      end
      if (is_np) begin
        tx_fc_r.nph <= body_r.hdr_fc;
        tx_fc_r.npd <= body_r.data_fc;
      end
      fc1_seen_r <= fc1_seen_r | {body_r.dllp_type == INITFC1_CPL,
                                  body_r.dllp_type == INITFC1_NP,
                                  body_r.dllp_type == INITFC1_P};
      fc2_seen_r <= fc2_seen_r | {body_r.dllp_type == INITFC2_CPL,
                                  body_r.dllp_type == INITFC2_NP,
                                  body_r.dllp_type == INITFC2_P};
    end
  end

  // one-cycle report in the process state
  always_comb begin
    ack_o = '0;
    if (in_process && (body_r.dllp_type inside {DLLP_ACK, DLLP_NAK})) begin
      ack_o.vld    = 1'b1;
      ack_o.is_ack = body_r.dllp_type == DLLP_ACK;
      ack_o.seq    = body_r.data_fc;
    end
  end

  assign tx_fc_o    = tx_fc_r;
  assign fc1_done_o = &fc1_seen_r;
  assign fc2_done_o = &fc2_seen_r;
  assign crc_err_o  = crc_err_r;

endmodule

`default_nettype wire

/* verilog/ack_nak_sched.sv */
/*
 * ack_nak_sched
 * tracks the next expected TLP sequence number and keeps one
 * pending Ack or Nak request for the transmit arbiter
 */
`default_nettype none

module ack_nak_sched (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_dll_pkg::rx_tlp_t   rx_tlp_i,
  input  logic                    grant_i,
  output pcie_dll_pkg::dllp_req_t req_o
);
  import pcie_dll_pkg::*;

  logic [11:0] exp_seq_r;
  logic        nak_held_r;
  logic        req_vld_r;
  dllp_t       req_body_r;
  dllp_t       next_body;
  logic        in_order;
  logic        load_req;

  assign in_order = rx_tlp_i.vld && rx_tlp_i.good && (rx_tlp_i.seq == exp_seq_r);
  // a second Nak waits for the next in-order TLP
  assign load_req = in_order || (rx_tlp_i.vld && !nak_held_r);

  always_comb begin
    next_body           = '0;
    next_body.dllp_type = in_order ? DLLP_ACK : DLLP_NAK;
    next_body.data_fc   = in_order ? rx_tlp_i.seq : exp_seq_r - 12'd1;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      exp_seq_r  <= '0;
      nak_held_r <= 1'b0;
      req_vld_r  <= 1'b0;
    end else if (load_req) begin
      if (in_order) begin
        exp_seq_r <= exp_seq_r + 12'd1;
      end
      nak_held_r <= !in_order;
      req_vld_r  <= 1'b1;
    end else if (grant_i) begin
      req_vld_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_body_r <= next_body;
    end
  end

  assign req_o = '{vld: req_vld_r, body: req_body_r};

endmodule

`default_nettype wire

/* verilog/fc_update_sched.sv */
/*
 * fc_update_sched
 * cumulative advertised credits, the InitFC1/InitFC2 sequence
 * after link up and UpdateFC requests on credit release
 */
`default_nettype none

module fc_update_sched (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      link_up_i,
  input  pcie_dll_pkg::fc_release_t release_i,
  input  logic                      grant_i,
  output pcie_dll_pkg::dllp_req_t   req_o
);
  import pcie_dll_pkg::*;

  fc_credits_t tot_r;
  logic        link_r;
  logic [2:0]  step_r;
  logic        dirty_p_r;
  logic        dirty_np_r;
  logic        rel_p;
  logic        rel_np;
  logic        init_busy;
  logic        sel_p;
  logic        sel_np;
  dllp_t       body_c;

  assign rel_p     = release_i.p_hdr || (release_i.p_data != 4'd0);
  assign rel_np    = release_i.np_hdr || (release_i.np_data != 4'd0);
  assign init_busy = step_r != FC_INIT_STEPS;
  // P update goes first when both classes are dirty
  assign sel_p     = !init_busy && dirty_p_r;
  assign sel_np    = !init_busy && !dirty_p_r && dirty_np_r;

  always_comb begin
    body_c = '0;
    case (step_r)
      3'd0:    body_c.dllp_type = INITFC1_P;
      3'd1:    body_c.dllp_type = INITFC1_NP;
      3'd2:    body_c.dllp_type = INITFC1_CPL;
      3'd3:    body_c.dllp_type = INITFC2_P;
      3'd4:    body_c.dllp_type = INITFC2_NP;
      3'd5:    body_c.dllp_type = INITFC2_CPL;
      default: body_c.dllp_type = sel_p ? UPDATEFC_P : UPDATEFC_NP;
    endcase
    // Cpl credits stay zero, meaning infinite
    if (body_c.dllp_type inside {INITFC1_P, INITFC2_P, UPDATEFC_P}) begin
      body_c.hdr_fc  = tot_r.ph;
      body_c.data_fc = tot_r.pd;
    end else if (body_c.dllp_type inside {INITFC1_NP, INITFC2_NP, UPDATEFC_NP}) begin
      body_c.hdr_fc  = tot_r.nph;
      body_c.data_fc = tot_r.npd;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tot_r      <= '{ph: INIT_PH, pd: INIT_PD, nph: INIT_NPH, npd: INIT_NPD};
      link_r     <= 1'b0;
      step_r     <= '0;
      dirty_p_r  <= 1'b0;
      dirty_np_r <= 1'b0;
    end else begin
      link_r     <= link_up_i;
      tot_r.ph   <= tot_r.ph + 8'(release_i.p_hdr);
      tot_r.pd   <= tot_r.pd + 12'(release_i.p_data);
      tot_r.nph  <= tot_r.nph + 8'(release_i.np_hdr);
      tot_r.npd  <= tot_r.npd + 12'(release_i.np_data);
      dirty_p_r  <= (dirty_p_r && !(grant_i && sel_p)) || rel_p;
      dirty_np_r <= (dirty_np_r && !(grant_i && sel_np)) || rel_np;
      // handshake restarts on the next link up
      if (!link_up_i) begin
        step_r <= '0;
      end else if (grant_i && init_busy) begin
        step_r <= step_r + 3'd1;
      end
    end
  end

  assign req_o = '{vld: (link_r && init_busy) || sel_p || sel_np, body: body_c};

endmodule

`default_nettype wire

/* verilog/dllp_tx_arbiter.sv */
/*
 * dllp_tx_arbiter
 * round-robin between the Ack/Nak and flow-control schedulers,
 * sends the granted body and its CRC as two beats on the tx stream
 */
`default_nettype none

module dllp_tx_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_dll_pkg::dllp_req_t ack_req_i,
  input  pcie_dll_pkg::dllp_req_t fc_req_i,
  output logic                    ack_grant_o,
  output logic                    fc_grant_o,
  output logic                    tx_valid_o,
  output pcie_dll_pkg::phy_beat_t tx_beat_o,
  input  logic                    tx_ready_i
);
  import pcie_dll_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BODY,
    ST_CRC
  } tx_state_e;

  tx_state_e   state_r;
  logic        fc_first_r;
  dllp_t       body_r;
  logic [15:0] body_crc;
  logic        tx_xfer;

  dllp_crc16 crc_i (
    .body_i(body_r),
    .crc_o (body_crc)
  );

  // grants only while idle, so a new body waits for the CRC beat
  always_comb begin
    ack_grant_o = 1'b0;
    fc_grant_o  = 1'b0;
    if (state_r == ST_IDLE) begin
      if (ack_req_i.vld && (!fc_req_i.vld || !fc_first_r)) begin
        ack_grant_o = 1'b1;
      end else if (fc_req_i.vld) begin
        fc_grant_o = 1'b1;
      end
    end
  end

  assign tx_xfer = tx_valid_o && tx_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r    <= ST_IDLE;
      fc_first_r <= 1'b0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (ack_grant_o || fc_grant_o) begin
            state_r    <= ST_BODY;
            // the loser gets priority next time
            fc_first_r <= ack_grant_o;
          end
        end
        ST_BODY: begin
          if (tx_xfer) begin
            state_r <= ST_CRC;
          end
        end
        ST_CRC: begin
          if (tx_xfer) begin
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ack_grant_o) begin
      body_r <= ack_req_i.body;
    end else if (fc_grant_o) begin
      body_r <= fc_req_i.body;
    end
  end

  assign tx_valid_o = state_r != ST_IDLE;

  always_comb begin
    tx_beat_o.is_dllp = 1'b1;
    tx_beat_o.last    = state_r == ST_CRC;
    if (state_r == ST_CRC) begin
      tx_beat_o.data = {16'h0000, body_crc};
    end else begin
      tx_beat_o.data = body_r;
    end
  end

endmodule

`default_nettype wire

/* verilog/pcie_dll_top.sv */
/*
 * pcie_dll_top
 * DLLP part of the data link layer: receive handler, Ack/Nak and
 * flow-control schedulers sharing the tx stream through the arbiter
 */
`default_nettype none

module pcie_dll_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      link_up_i,
  input  logic                      rx_valid_i,
  input  pcie_dll_pkg::phy_beat_t   rx_beat_i,
  output logic                      rx_ready_o,
  output logic                      tx_valid_o,
  output pcie_dll_pkg::phy_beat_t   tx_beat_o,
  input  logic                      tx_ready_i,
  input  pcie_dll_pkg::rx_tlp_t     rx_tlp_i,
  input  pcie_dll_pkg::fc_release_t fc_release_i,
  output pcie_dll_pkg::seq_ack_t    ack_o,
  output pcie_dll_pkg::fc_credits_t tx_fc_o,
  output logic                      fc_init_done_o,
  output logic                      crc_err_o
);
  import pcie_dll_pkg::*;

  dllp_req_t ack_req;
  dllp_req_t fc_req;
  logic      ack_grant;
  logic      fc_grant;

  dllp_handler handler_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .link_up_i (link_up_i),
    .rx_valid_i(rx_valid_i),
    .rx_beat_i (rx_beat_i),
    .rx_ready_o(rx_ready_o),
    .ack_o     (ack_o),
    .tx_fc_o   (tx_fc_o),
    .fc1_done_o(),
    .fc2_done_o(fc_init_done_o),
    .crc_err_o (crc_err_o)
  );

  ack_nak_sched ack_sched_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .rx_tlp_i(rx_tlp_i),
    .grant_i (ack_grant),
    .req_o   (ack_req)
  );

  fc_update_sched fc_sched_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .link_up_i(link_up_i),
    .release_i(fc_release_i),
    .grant_i  (fc_grant),
    .req_o    (fc_req)
  );

  dllp_tx_arbiter arbiter_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ack_req_i  (ack_req),
    .fc_req_i   (fc_req),
    .ack_grant_o(ack_grant),
    .fc_grant_o (fc_grant),
    .tx_valid_o (tx_valid_o),
    .tx_beat_o  (tx_beat_o),
    .tx_ready_i (tx_ready_i)
  );

endmodule

`default_nettype wire

/* bench/pcie_dll_assertions.sv */
/*
 * pcie_dll_assertions
 * stream stability, one-cycle pulses and busy/accept rules,
 * bound to the handler and to the tx arbiter
 */
`default_nettype none

module pcie_dll_assertions (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    valid_i,
  input logic                    ready_i,
  input pcie_dll_pkg::phy_beat_t beat_i,
  input logic                    pulse_a_i,
  input logic                    pulse_b_i,
  input logic                    busy_i,
  input logic                    accept_i
);
  // beat held while stalled
  assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i && !ready_i |=> valid_i && $stable(beat_i))
    else $error("stream beat changed while stalled");

  assert property (@(posedge clk_i) disable iff (rst_i) pulse_a_i |=> !pulse_a_i)
    else $error("pulse a longer than one cycle");

  assert property (@(posedge clk_i) disable iff (rst_i) pulse_b_i |=> !pulse_b_i)
    else $error("pulse b longer than one cycle");

  // nothing new accepted while busy
  assert property (@(posedge clk_i) disable iff (rst_i) busy_i |-> !accept_i)
    else $error("accept high while busy");

endmodule

`default_nettype wire

/* bench/pcie_dll_tb.sv */
/*
 * pcie_dll_tb
 * random DLLP, TLP and credit stimulus for the DLLP layer,
 * checked against a reference model of the decode and schedule rules
 */
`default_nettype none

module pcie_dll_tb;
  import pcie_dll_pkg::*;

  logic        clk_i, rst_i, link_up_i, rx_valid_i, rx_ready_o, tx_valid_o, tx_ready_i;
  logic        fc_init_done_o, crc_err_o;
  phy_beat_t   rx_beat_i, tx_beat_o;
  rx_tlp_t     rx_tlp_i;
  fc_release_t fc_release_i;
  seq_ack_t    ack_o;
  fc_credits_t tx_fc_o;

  logic [31:0] lfsr_r = 32'hcbf0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  int          test_err0;
  logic        bp_on = 1'b0;
  dllp_t       mon_body;
  dllp_t       exp_ack_q[$], exp_fc_q[$], got_ack_q[$], got_fc_q[$];
  // model state
  fc_credits_t m_tx_fc = '0;
  fc_credits_t m_tot = '{ph: INIT_PH, pd: INIT_PD, nph: INIT_NPH, npd: INIT_NPD};
  logic [2:0]  m_fc2 = '0;
  logic [11:0] m_exp_seq = '0;
  logic        m_nak_held = 1'b0;

  pcie_dll_top dut_i (.*);

  bind dllp_tx_arbiter pcie_dll_assertions tx_chk_i (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(tx_valid_o), .ready_i(tx_ready_i),
    .beat_i(tx_beat_o), .pulse_a_i(ack_grant_o), .pulse_b_i(fc_grant_o),
    .busy_i(tx_valid_o), .accept_i(ack_grant_o || fc_grant_o));
  bind dllp_handler pcie_dll_assertions rx_chk_i (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(rx_valid_i), .ready_i(rx_ready_o),
    .beat_i(rx_beat_i), .pulse_a_i(ack_o.vld), .pulse_b_i(crc_err_o),
    .busy_i(in_process), .accept_i(rx_ready_o));

  always #20 clk_i = ~clk_i;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_r[0]};
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ 32'hA3000000) : (lfsr_r >> 1);
    end
    return r;
  endfunction

  function automatic logic [15:0] crc_model(logic [31:0] d);
    logic [15:0] c;
    logic        fb;
    c = CRC_INIT;
    for (int i = 31; i >= 0; i--) begin
      fb = c[15] ^ d[i];
      c  = {c[14:0], 1'b0};
      if (fb) c = c ^ CRC_POLY;
    end
    return ~c;
  endfunction

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_ack(input seq_ack_t got, input seq_ack_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %p expected %p", $time, what, got, exp);
    end
  endtask

  task automatic check_fc(input fc_credits_t got, input fc_credits_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %p expected %p", $time, what, got, exp);
    end
  endtask

  task automatic check_dllp(input dllp_t got, input dllp_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_crc(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: tx crc got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != test_err0) tests_bad++;
    $display("test %s: %s", name, (err_cnt == test_err0) ? "ok" : "errors");
    test_err0 = err_cnt;
  endtask

  // back-pressure on the tx stream
  always @(posedge clk_i) begin
    tx_ready_i <= bp_on ? 1'(rand_bits(1)) : 1'b1;
  end

  // tx monitor, sorted by scheduler so either arbitration order is accepted
  always @(posedge clk_i) begin
    if (!rst_i && tx_valid_o && tx_ready_i) begin
      check_bit(tx_beat_o.is_dllp, 1'b1, "tx is_dllp");
      if (!tx_beat_o.last) begin
        mon_body = dllp_t'(tx_beat_o.data);
      end else begin
        check_crc(tx_beat_o.data[15:0], crc_model(mon_body));
        if (mon_body.dllp_type inside {DLLP_ACK, DLLP_NAK}) got_ack_q.push_back(mon_body);
        else got_fc_q.push_back(mon_body);
      end
    end
  end

  function automatic dllp_t make_body(dllp_type_e t, logic [7:0] hdr, logic [11:0] data);
    dllp_t b;
    b = '0;
    b.dllp_type = t;
    b.hdr_fc    = hdr;
    b.data_fc   = data;
    return b;
  endfunction

  // wait for all expected DLLPs, then a quiet period, then compare
  task automatic drain(input string what);
    int n;
    n = 0;
    while (got_ack_q.size() < exp_ack_q.size() || got_fc_q.size() < exp_fc_q.size()) begin
      @(negedge clk_i);
      n++;
      if (n > 3000) timeout_fail(what);
    end
    repeat (30) @(negedge clk_i);
    check_bit(got_ack_q.size() == exp_ack_q.size(), 1'b1, {what, " ack/nak count"});
    check_bit(got_fc_q.size() == exp_fc_q.size(), 1'b1, {what, " fc count"});
    while (got_ack_q.size() > 0 && exp_ack_q.size() > 0)
      check_dllp(got_ack_q.pop_front(), exp_ack_q.pop_front(), {what, " ack/nak"});
    while (got_fc_q.size() > 0 && exp_fc_q.size() > 0)
      check_dllp(got_fc_q.pop_front(), exp_fc_q.pop_front(), {what, " fc"});
    got_ack_q.delete();
    got_fc_q.delete();
    exp_ack_q.delete();
    exp_fc_q.delete();
  endtask

  task automatic send_beat(input phy_beat_t b);
    int n;
    n = 0;
    @(posedge clk_i);
    rx_valid_i <= 1'b1;
    rx_beat_i  <= b;
    do begin
      @(negedge clk_i);
      n++;
      if (n > 200) timeout_fail("rx_ready_o");
    end while (!rx_ready_o);
    @(posedge clk_i);
    rx_valid_i <= 1'b0;
  endtask

  task automatic rx_dllp(input dllp_t b, input logic corrupt);
    logic [15:0] crc;
    seq_ack_t    exp_ack;
    int          n;
    crc = crc_model(b);
    if (corrupt) crc = crc ^ (16'(rand_bits(16)) | 16'h0001);
    send_beat('{data: b, is_dllp: 1'b1, last: 1'b0});
    send_beat('{data: {16'h0000, crc}, is_dllp: 1'b1, last: 1'b1});
    exp_ack = '0;
    if (!corrupt) begin
      if (b.dllp_type inside {DLLP_ACK, DLLP_NAK})
        exp_ack = '{vld: 1'b1, is_ack: b.dllp_type == DLLP_ACK, seq: b.data_fc};
      if (b.dllp_type inside {INITFC1_P, INITFC2_P, UPDATEFC_P}) begin
        m_tx_fc.ph = b.hdr_fc;
        m_tx_fc.pd = b.data_fc;
      end
      if (b.dllp_type inside {INITFC1_NP, INITFC2_NP, UPDATEFC_NP}) begin
        m_tx_fc.nph = b.hdr_fc;
        m_tx_fc.npd = b.data_fc;
      end
      m_fc2 |= {b.dllp_type == INITFC2_CPL, b.dllp_type == INITFC2_NP,
                b.dllp_type == INITFC2_P};
    end
    @(negedge clk_i);
    check_ack(ack_o, exp_ack, "ack_o");
    check_bit(crc_err_o, corrupt, "crc_err_o");
    @(negedge clk_i);
    check_fc(tx_fc_o, m_tx_fc, "tx_fc_o");
    check_bit(fc_init_done_o, &m_fc2, "fc_init_done_o");
    n = 0;
    while (!rx_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > 200) timeout_fail("rx idle");
    end
  endtask

  task automatic tlp_event(output rx_tlp_t t);
    logic [2:0] kind;
    kind  = 3'(rand_bits(3));
    t.vld = 1'b1;
    t.good = kind < 3'd6;
    t.seq  = (kind == 3'd5) ? m_exp_seq + 12'd1 + 12'(rand_bits(3)) : m_exp_seq;
    if (t.good && t.seq == m_exp_seq) begin
      exp_ack_q.push_back(make_body(DLLP_ACK, 8'd0, m_exp_seq));
      m_exp_seq++;
      m_nak_held = 1'b0;
    end else if (!m_nak_held) begin
      exp_ack_q.push_back(make_body(DLLP_NAK, 8'd0, m_exp_seq - 12'd1));
      m_nak_held = 1'b1;
    end
  endtask

  task automatic release_event(output fc_release_t r);
    r = fc_release_t'(10'(rand_bits(10)));
    m_tot.ph  += 8'(r.p_hdr);
    m_tot.pd  += 12'(r.p_data);
    m_tot.nph += 8'(r.np_hdr);
    m_tot.npd += 12'(r.np_data);
    if (r.p_hdr || r.p_data != 0) exp_fc_q.push_back(make_body(UPDATEFC_P, m_tot.ph, m_tot.pd));
    if (r.np_hdr || r.np_data != 0)
      exp_fc_q.push_back(make_body(UPDATEFC_NP, m_tot.nph, m_tot.npd));
  endtask

  initial begin
    dllp_type_e  rx_types[8];
    dllp_type_e  t;
    dllp_t       b;
    rx_tlp_t     tlp;
    fc_release_t rel;
    rx_types = '{DLLP_ACK, DLLP_NAK, INITFC1_P, INITFC2_P, INITFC2_NP, INITFC2_CPL,
                 UPDATEFC_P, UPDATEFC_NP};
    clk_i = 1'b0;
    rst_i = 1'b1;
    link_up_i = 1'b0;
    rx_valid_i = 1'b0;
    rx_beat_i = '0;
    tx_ready_i = 1'b1;
    rx_tlp_i = '0;
    fc_release_i = '0;
    test_err0 = 0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    // reset values, link down
    repeat (10) begin
      @(negedge clk_i);
      check_bit(rx_ready_o, 1'b0, "rx_ready_o");
      check_bit(tx_valid_o, 1'b0, "tx_valid_o");
      check_bit(fc_init_done_o, 1'b0, "fc_init_done_o");
      check_fc(tx_fc_o, '0, "tx_fc_o");
    end
    end_test("reset");

    bp_on = 1'b1;
    @(posedge clk_i);
    link_up_i <= 1'b1;
    exp_fc_q.push_back(make_body(INITFC1_P, INIT_PH, INIT_PD));
    exp_fc_q.push_back(make_body(INITFC1_NP, INIT_NPH, INIT_NPD));
    exp_fc_q.push_back(make_body(INITFC1_CPL, 8'd0, 12'd0));
    exp_fc_q.push_back(make_body(INITFC2_P, INIT_PH, INIT_PD));
    exp_fc_q.push_back(make_body(INITFC2_NP, INIT_NPH, INIT_NPD));
    exp_fc_q.push_back(make_body(INITFC2_CPL, 8'd0, 12'd0));
    drain("init fc");
    end_test("init_fc");

    for (int i = 0; i < 40; i++) begin
      t = rx_types[rand_bits(3)];
      if (t inside {DLLP_ACK, DLLP_NAK}) b = make_body(t, 8'd0, 12'(rand_bits(12)));
      else b = make_body(t, 8'(rand_bits(8)), 12'(rand_bits(12)));
      rx_dllp(b, rand_bits(2) == 2'd0);
    end
    rx_dllp(make_body(INITFC2_P, 8'd5, 12'd50), 1'b0);
    rx_dllp(make_body(INITFC2_NP, 8'd6, 12'd60), 1'b0);
    rx_dllp(make_body(INITFC2_CPL, 8'd0, 12'd0), 1'b0);
    check_bit(fc_init_done_o, 1'b1, "fc_init_done_o final");
    end_test("rx_dllp");

    for (int i = 0; i < 30; i++) begin
      tlp_event(tlp);
      @(posedge clk_i);
      rx_tlp_i <= tlp;
      @(posedge clk_i);
      rx_tlp_i <= '0;
      drain("tlp");
    end
    end_test("ack_nak");

    for (int i = 0; i < 20; i++) begin
      release_event(rel);
      @(posedge clk_i);
      fc_release_i <= rel;
      @(posedge clk_i);
      fc_release_i <= '0;
      drain("release");
    end
    end_test("update_fc");

    // both schedulers at once
    for (int i = 0; i < 20; i++) begin
      tlp_event(tlp);
      release_event(rel);
      @(posedge clk_i);
      rx_tlp_i <= tlp;
      fc_release_i <= rel;
      @(posedge clk_i);
      rx_tlp_i <= '0;
      fc_release_i <= '0;
      drain("mixed");
    end
    end_test("mixed");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pcie_dll.f */
verilog/pcie_dll_pkg.sv
verilog/dllp_crc16.sv
verilog/dllp_handler.sv
verilog/ack_nak_sched.sv
verilog/fc_update_sched.sv
verilog/dllp_tx_arbiter.sv
verilog/pcie_dll_top.sv
bench/pcie_dll_assertions.sv
bench/pcie_dll_tb.sv

/* Makefile */
# Verilator simulation of the DLLP data link layer

TOP := pcie_dll_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pcie_dll.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
